//--- mesh_pkg.sv
// fixed 32-bit packet; 3-bit coordinates cap the mesh at 6x6 pods and tag ids cap it at 16 pods
package mesh_pkg;

  // coordinate, memory and payload widths
  localparam int cord_width   = 3;
  localparam int addr_width   = 2;
  localparam int data_width   = 16;
  localparam int pad_width    = 8;
  localparam int pkt_width    = 32;

  // pod index field of a tag frame
  localparam int tag_id_width = 4;

  // mesh ports per router, local port included
  localparam int num_dirs     = 5;

  typedef enum logic [1:0] {
    op_store,
    op_load,
    op_store_ack,
    op_load_data
  } op_e;

  // request as seen by the tile
  typedef struct packed {
    logic [cord_width-1:0] dest_x;
    logic [cord_width-1:0] dest_y;
    op_e                   op;
    logic [cord_width-1:0] src_x;
    logic [cord_width-1:0] src_y;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
  } pkt_req_s;

  // response back to the requester, destination sits where the request keeps it
  typedef struct packed {
    logic [cord_width-1:0] dest_x;
    logic [cord_width-1:0] dest_y;
    op_e                   op;
    logic [pad_width-1:0]  pad;
    logic [data_width-1:0] data;
  } pkt_rsp_s;

  typedef union packed {
    pkt_req_s req;
    pkt_rsp_s rsp;
  } pkt_u;

  // router port index, local port first so it wins arbitration
  typedef enum logic [2:0] {
    dir_p,
    dir_w,
    dir_e,
    dir_n,
    dir_s
  } link_dir_e;

endpackage

//--- tag_client.sv
// tag line must idle low between frames; a frame is start 1, 4 index bits msb first, payload
`timescale 1ns/10ps

module tag_client
  import mesh_pkg::*;
  #(
    parameter int pod_id_p = 0
  )
  (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic tag_i,
    output logic pod_reset_o
  );

  localparam int cnt_width_lp = $clog2(tag_id_width);

  localparam logic [1:0] st_idle    = 2'd0;
  localparam logic [1:0] st_index   = 2'd1;
  localparam logic [1:0] st_payload = 2'd2;

  logic [1:0]              state_r;
  logic [cnt_width_lp-1:0] bit_cnt_r;
  logic [tag_id_width-1:0] index_r;
  logic                    id_match;

  // only frames for this pod touch the reset command
  assign id_match = (index_r == tag_id_width'(pod_id_p));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r     <= st_idle;
      bit_cnt_r   <= '0;
      index_r     <= '0;
      pod_reset_o <= 1'b1;
    end else begin
      case (state_r)
        st_idle: begin
          // start bit
          if (tag_i) begin
            state_r   <= st_index;
            bit_cnt_r <= '0;
          end
        end
        st_index: begin
          index_r   <= {index_r[tag_id_width-2:0], tag_i};
          bit_cnt_r <= bit_cnt_r + 1'b1;
          if (bit_cnt_r == cnt_width_lp'(tag_id_width - 1)) begin
            state_r <= st_payload;
          end
        end
        st_payload: begin
          // payload 1 holds the pod in reset, 0 releases it
          if (id_match) begin
            pod_reset_o <= tag_i;
          end
          state_r <= st_idle;
        end
        default: begin
          state_r <= st_idle;
        end
      endcase
    end
  end

endmodule

//--- reset_delay.sv
// reset_depth_p must be at least 1; release lags the falling command by exactly that many cycles
`timescale 1ns/10ps

module reset_delay
  #(
    parameter int reset_depth_p = 3
  )
  (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic reset_cmd_i,
    output logic pod_reset_o
  );

  localparam int cnt_width_lp = $clog2(reset_depth_p + 1);

  logic [cnt_width_lp-1:0] cnt_r;
  logic [cnt_width_lp-1:0] cnt_n;

  // reload while the command holds, then count down to zero
  always_comb begin
    if (reset_cmd_i) begin
      cnt_n = cnt_width_lp'(reset_depth_p);
    end else if (cnt_r != '0) begin
      cnt_n = cnt_r - 1'b1;
    end else begin
      cnt_n = cnt_r;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_r       <= cnt_width_lp'(reset_depth_p);
      pod_reset_o <= 1'b1;
    end else begin
      cnt_r       <= cnt_n;
      pod_reset_o <= reset_cmd_i | (cnt_n != '0);
    end
  end

endmodule

//--- pod_router.sv
// one-entry input buffers give half rate per link; fixed priority can starve low inputs under load
`timescale 1ns/10ps

module pod_router
  import mesh_pkg::*;
  (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  pod_reset_i,
    input  logic [cord_width-1:0] my_x_i,
    input  logic [cord_width-1:0] my_y_i,

    input  pkt_u [num_dirs-1:0]   link_data_i,
    input  logic [num_dirs-1:0]   link_valid_i,
    output logic [num_dirs-1:0]   link_ready_o,

    output pkt_u [num_dirs-1:0]   link_data_o,
    output logic [num_dirs-1:0]   link_valid_o,
    input  logic [num_dirs-1:0]   link_ready_i
  );

  pkt_u      [num_dirs-1:0] buf_r;
  logic      [num_dirs-1:0] full_r;
  logic                     live_r;

  link_dir_e [num_dirs-1:0] route;
  link_dir_e [num_dirs-1:0] out_sel;
  logic      [num_dirs-1:0] out_v;
  logic      [num_dirs-1:0] sent;

  logic      [num_dirs-1:0] lock_r;
  link_dir_e [num_dirs-1:0] lock_idx_r;

  // live_r lags the pod reset by one cycle so inputs open only after release
  assign link_ready_o = {num_dirs{live_r}} & ~full_r;

  // x first, then y
  always_comb begin
    for (int i = 0; i < num_dirs; i++) begin
      if (buf_r[i].req.dest_x < my_x_i) begin
        route[i] = dir_w;
      end else if (buf_r[i].req.dest_x > my_x_i) begin
        route[i] = dir_e;
      end else if (buf_r[i].req.dest_y < my_y_i) begin
        route[i] = dir_n;
      end else if (buf_r[i].req.dest_y > my_y_i) begin
        route[i] = dir_s;
      end else begin
        route[i] = dir_p;
      end
    end
  end

  // per output grant; a held grant sticks until its packet moves
  always_comb begin
    out_v   = '0;
    out_sel = {num_dirs{dir_p}};
    for (int o = 0; o < num_dirs; o++) begin
      if (lock_r[o]) begin
        out_v[o]   = 1'b1;
        out_sel[o] = lock_idx_r[o];
      end else begin
        // scan downward so the lowest index ends up winning
        for (int i = num_dirs - 1; i >= 0; i--) begin
          if (full_r[i] && (route[i] == link_dir_e'(o))) begin
            out_v[o]   = 1'b1;
            out_sel[o] = link_dir_e'(i);
          end
        end
      end
    end
  end

  always_comb begin
    sent = '0;
    for (int o = 0; o < num_dirs; o++) begin
      link_valid_o[o] = out_v[o];
      link_data_o[o]  = buf_r[out_sel[o]];
      if (out_v[o] && link_ready_i[o]) begin
        sent[out_sel[o]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      live_r     <= 1'b0;
      full_r     <= '0;
      lock_r     <= '0;
      lock_idx_r <= {num_dirs{dir_p}};
    end else if (pod_reset_i) begin
      live_r     <= 1'b0;
      full_r     <= '0;
      lock_r     <= '0;
      lock_idx_r <= {num_dirs{dir_p}};
    end else begin
      live_r <= 1'b1;
      for (int i = 0; i < num_dirs; i++) begin
        if (sent[i]) begin
          full_r[i] <= 1'b0;
        end else if (link_valid_i[i] && link_ready_o[i]) begin
          full_r[i] <= 1'b1;
        end
      end
      for (int o = 0; o < num_dirs; o++) begin
        lock_r[o]     <= out_v[o] & ~link_ready_i[o];
        lock_idx_r[o] <= out_sel[o];
      end
    end
  end

  // buffer payload, only meaningful while full_r is set
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < num_dirs; i++) begin
      if (link_valid_i[i] && link_ready_o[i]) begin
        buf_r[i] <= link_data_i[i];
      end
    end
  end

endmodule

//--- pod_tile.sv
// any op other than store is served as a load; pad returns the answering pod's coordinates
`timescale 1ns/10ps

module pod_tile
  import mesh_pkg::*;
  (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  pod_reset_i,
    input  logic [cord_width-1:0] my_x_i,
    input  logic [cord_width-1:0] my_y_i,

    input  pkt_u                  req_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,

    output pkt_u                  rsp_o,
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i
  );

  localparam int words_lp = 2 ** addr_width;

  logic [data_width-1:0] mem_r [words_lp];
  logic                  live_r;
  logic                  rsp_valid_r;
  logic                  accept;
  logic                  is_store;
  pkt_rsp_s              rsp_n;

  // single outstanding response, so a waiting answer blocks the next request
  assign req_ready_o = live_r & ~rsp_valid_r;
  assign accept      = req_valid_i & req_ready_o;
  assign is_store    = (req_i.req.op == op_store);
  assign rsp_valid_o = rsp_valid_r;

  always_comb begin
    rsp_n.dest_x = req_i.req.src_x;
    rsp_n.dest_y = req_i.req.src_y;
    rsp_n.op     = is_store ? op_store_ack : op_load_data;
    rsp_n.pad    = pad_width'({my_x_i, my_y_i});
    // store echoes the written word
    rsp_n.data   = is_store ? req_i.req.data : mem_r[req_i.req.addr];
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      live_r      <= 1'b0;
      rsp_valid_r <= 1'b0;
    end else if (pod_reset_i) begin
      live_r      <= 1'b0;
      rsp_valid_r <= 1'b0;
    end else begin
      live_r <= 1'b1;
      if (accept) begin
        rsp_valid_r <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_r <= 1'b0;
      end
    end
  end

  // pod reset wipes the memory to zero
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < words_lp; i++) begin
        mem_r[i] <= '0;
      end
    end else if (pod_reset_i) begin
      for (int i = 0; i < words_lp; i++) begin
        mem_r[i] <= '0;
      end
    end else if (accept && is_store) begin
      mem_r[req_i.req.addr] <= req_i.req.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_o.rsp <= rsp_n;
    end
  end

endmodule

//--- pod_array.sv
// pod (x,y) sits at coordinate (x+1,y+1) with tag id y*num_pods_x_p+x; row 0 is the north row
`timescale 1ns/10ps

module pod_array
  import mesh_pkg::*;
  #(
    parameter int num_pods_x_p  = 2,
    parameter int num_pods_y_p  = 2,
    parameter int reset_depth_p = 3
  )
  (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  logic                                  tag_i,

    // row edge links
    input  logic [num_pods_y_p-1:0][pkt_width-1:0] west_data_i,
    input  logic [num_pods_y_p-1:0]                west_valid_i,
    output logic [num_pods_y_p-1:0]                west_ready_o,
    output logic [num_pods_y_p-1:0][pkt_width-1:0] west_data_o,
    output logic [num_pods_y_p-1:0]                west_valid_o,
    input  logic [num_pods_y_p-1:0]                west_ready_i,

    input  logic [num_pods_y_p-1:0][pkt_width-1:0] east_data_i,
    input  logic [num_pods_y_p-1:0]                east_valid_i,
    output logic [num_pods_y_p-1:0]                east_ready_o,
    output logic [num_pods_y_p-1:0][pkt_width-1:0] east_data_o,
    output logic [num_pods_y_p-1:0]                east_valid_o,
    input  logic [num_pods_y_p-1:0]                east_ready_i,

    // column edge links
    input  logic [num_pods_x_p-1:0][pkt_width-1:0] north_data_i,
    input  logic [num_pods_x_p-1:0]                north_valid_i,
    output logic [num_pods_x_p-1:0]                north_ready_o,
    output logic [num_pods_x_p-1:0][pkt_width-1:0] north_data_o,
    output logic [num_pods_x_p-1:0]                north_valid_o,
    input  logic [num_pods_x_p-1:0]                north_ready_i,

    input  logic [num_pods_x_p-1:0][pkt_width-1:0] south_data_i,
    input  logic [num_pods_x_p-1:0]                south_valid_i,
    output logic [num_pods_x_p-1:0]                south_ready_o,
    output logic [num_pods_x_p-1:0][pkt_width-1:0] south_data_o,
    output logic [num_pods_x_p-1:0]                south_valid_o,
    input  logic [num_pods_x_p-1:0]                south_ready_i
  );

  // router side of every link, indexed [row][column][port]
  wire pkt_u [num_pods_y_p-1:0][num_pods_x_p-1:0][num_dirs-1:0] rtr_data_li;
  wire pkt_u [num_pods_y_p-1:0][num_pods_x_p-1:0][num_dirs-1:0] rtr_data_lo;
  wire logic [num_pods_y_p-1:0][num_pods_x_p-1:0][num_dirs-1:0] rtr_valid_li;
  wire logic [num_pods_y_p-1:0][num_pods_x_p-1:0][num_dirs-1:0] rtr_valid_lo;
  wire logic [num_pods_y_p-1:0][num_pods_x_p-1:0][num_dirs-1:0] rtr_ready_li;
  wire logic [num_pods_y_p-1:0][num_pods_x_p-1:0][num_dirs-1:0] rtr_ready_lo;

  wire logic [num_pods_y_p-1:0][num_pods_x_p-1:0] reset_cmd;
  wire logic [num_pods_y_p-1:0][num_pods_x_p-1:0] pod_reset;

  for (genvar y = 0; y < num_pods_y_p; y++) begin : py
    for (genvar x = 0; x < num_pods_x_p; x++) begin : px

      tag_client #(.pod_id_p(y * num_pods_x_p + x)) u_tag (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .tag_i(tag_i), .pod_reset_o(reset_cmd[y][x])
      );

      reset_delay #(.reset_depth_p(reset_depth_p)) u_rst (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .reset_cmd_i(reset_cmd[y][x]), .pod_reset_o(pod_reset[y][x])
      );

      pod_router u_router (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .pod_reset_i(pod_reset[y][x]),
        .my_x_i(cord_width'(x + 1)), .my_y_i(cord_width'(y + 1)),
        .link_data_i(rtr_data_li[y][x]), .link_valid_i(rtr_valid_li[y][x]),
        .link_ready_o(rtr_ready_lo[y][x]),
        .link_data_o(rtr_data_lo[y][x]), .link_valid_o(rtr_valid_lo[y][x]),
        .link_ready_i(rtr_ready_li[y][x])
      );

      // tile hangs off the local port
      pod_tile u_tile (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .pod_reset_i(pod_reset[y][x]),
        .my_x_i(cord_width'(x + 1)), .my_y_i(cord_width'(y + 1)),
        .req_i(rtr_data_lo[y][x][dir_p]), .req_valid_i(rtr_valid_lo[y][x][dir_p]),
        .req_ready_o(rtr_ready_li[y][x][dir_p]),
        .rsp_o(rtr_data_li[y][x][dir_p]), .rsp_valid_o(rtr_valid_li[y][x][dir_p]),
        .rsp_ready_i(rtr_ready_lo[y][x][dir_p])
      );

      if (x == 0) begin : g_w_edge
        assign rtr_data_li[y][x][dir_w]  = west_data_i[y];
        assign rtr_valid_li[y][x][dir_w] = west_valid_i[y];
        assign rtr_ready_li[y][x][dir_w] = west_ready_i[y];
        assign west_ready_o[y] = rtr_ready_lo[y][x][dir_w];
        assign west_data_o[y]  = rtr_data_lo[y][x][dir_w];
        assign west_valid_o[y] = rtr_valid_lo[y][x][dir_w];
      end else begin : g_w_link
        assign rtr_data_li[y][x][dir_w]  = rtr_data_lo[y][x-1][dir_e];
        assign rtr_valid_li[y][x][dir_w] = rtr_valid_lo[y][x-1][dir_e];
        assign rtr_ready_li[y][x][dir_w] = rtr_ready_lo[y][x-1][dir_e];
      end

      if (x == num_pods_x_p - 1) begin : g_e_edge
        assign rtr_data_li[y][x][dir_e]  = east_data_i[y];
        assign rtr_valid_li[y][x][dir_e] = east_valid_i[y];
        assign rtr_ready_li[y][x][dir_e] = east_ready_i[y];
        assign east_ready_o[y] = rtr_ready_lo[y][x][dir_e];
        assign east_data_o[y]  = rtr_data_lo[y][x][dir_e];
        assign east_valid_o[y] = rtr_valid_lo[y][x][dir_e];
      end else begin : g_e_link
        assign rtr_data_li[y][x][dir_e]  = rtr_data_lo[y][x+1][dir_w];
        assign rtr_valid_li[y][x][dir_e] = rtr_valid_lo[y][x+1][dir_w];
        assign rtr_ready_li[y][x][dir_e] = rtr_ready_lo[y][x+1][dir_w];
      end

      if (y == 0) begin : g_n_edge
        assign rtr_data_li[y][x][dir_n]  = north_data_i[x];
        assign rtr_valid_li[y][x][dir_n] = north_valid_i[x];
        assign rtr_ready_li[y][x][dir_n] = north_ready_i[x];
        assign north_ready_o[x] = rtr_ready_lo[y][x][dir_n];
        assign north_data_o[x]  = rtr_data_lo[y][x][dir_n];
        assign north_valid_o[x] = rtr_valid_lo[y][x][dir_n];
      end else begin : g_n_link
        assign rtr_data_li[y][x][dir_n]  = rtr_data_lo[y-1][x][dir_s];
        assign rtr_valid_li[y][x][dir_n] = rtr_valid_lo[y-1][x][dir_s];
        assign rtr_ready_li[y][x][dir_n] = rtr_ready_lo[y-1][x][dir_s];
      end

      if (y == num_pods_y_p - 1) begin : g_s_edge
        assign rtr_data_li[y][x][dir_s]  = south_data_i[x];
        assign rtr_valid_li[y][x][dir_s] = south_valid_i[x];
        assign rtr_ready_li[y][x][dir_s] = south_ready_i[x];
        assign south_ready_o[x] = rtr_ready_lo[y][x][dir_s];
        assign south_data_o[x]  = rtr_data_lo[y][x][dir_s];
        assign south_valid_o[x] = rtr_valid_lo[y][x][dir_s];
      end else begin : g_s_link
        assign rtr_data_li[y][x][dir_s]  = rtr_data_lo[y+1][x][dir_n];
        assign rtr_valid_li[y][x][dir_s] = rtr_valid_lo[y+1][x][dir_n];
        assign rtr_ready_li[y][x][dir_s] = rtr_ready_lo[y+1][x][dir_n];
      end

    end
  end

endmodule

//--- tb_pod_model.svh
// model for a 2x2 array; expects num_x_lp, num_y_lp and mesh_pkg in scope, edge lanes 0..7
`ifndef TB_POD_MODEL_SVH
`define TB_POD_MODEL_SVH

  // tile memories indexed [pod][word], pod = (y-1)*num_x_lp + (x-1)
  logic [data_width-1:0] model_mem [4][4];

  // packets expected at the edge, in the order they were injected
  pkt_u exp_pkt_q  [$];
  int   exp_port_q [$];
  int   exp_src_q  [$];
  int   outstanding [4];

  // edge lane is side*2+index, sides west, east, north, south
  function automatic int exit_port(input int sx, input int sy, input int dx, input int dy);
    if (dx < 1) begin
      return sy - 1;
    end else if (dx > num_x_lp) begin
      return 2 + sy - 1;
    end else if (dy < 1) begin
      return 4 + dx - 1;
    end else if (dy > num_y_lp) begin
      return 6 + dx - 1;
    end
    // a pod coordinate never leaves the array
    return -1;
  endfunction

  task automatic expect_pkt(input int port, input int src, input pkt_u pkt);
    exp_pkt_q.push_back(pkt);
    exp_port_q.push_back(port);
    exp_src_q.push_back(src);
    outstanding[src]++;
  endtask

  task automatic clear_model_pod(input int pod);
    for (int a = 0; a < 4; a++) begin
      model_mem[pod][a] = '0;
    end
  endtask

  task automatic init_model();
    for (int p = 0; p < 4; p++) begin
      clear_model_pod(p);
      outstanding[p] = 0;
    end
  endtask

`endif

//--- tb_pod_array.sv
// 2x2 array only; west and north edges inject, east and south inputs stay idle
`timescale 1ns/10ps

module tb_pod_array
  import mesh_pkg::*;
  ();

  localparam int num_x_lp       = 2;
  localparam int num_y_lp       = 2;
  localparam int reset_depth_lp = 3;
  localparam int n_mem_lp       = 12;
  localparam int n_pass_lp      = 12;
  localparam int total_pkts_lp  = 2 * (2 * n_mem_lp + 2 * n_pass_lp) + 16;
  localparam int cycle_limit_lp = 20 * total_pkts_lp + 500;

  logic clk_i;
  logic rst_n_i;
  logic tag_i;

  logic [num_y_lp-1:0][pkt_width-1:0] west_data_i;
  logic [num_y_lp-1:0][pkt_width-1:0] west_data_o;
  logic [num_y_lp-1:0][pkt_width-1:0] east_data_i;
  logic [num_y_lp-1:0][pkt_width-1:0] east_data_o;
  logic [num_x_lp-1:0][pkt_width-1:0] north_data_i;
  logic [num_x_lp-1:0][pkt_width-1:0] north_data_o;
  logic [num_x_lp-1:0][pkt_width-1:0] south_data_i;
  logic [num_x_lp-1:0][pkt_width-1:0] south_data_o;
  logic [num_y_lp-1:0] west_valid_i, west_ready_o, west_valid_o, west_ready_i;
  logic [num_y_lp-1:0] east_valid_i, east_ready_o, east_valid_o, east_ready_i;
  logic [num_x_lp-1:0] north_valid_i, north_ready_o, north_valid_o, north_ready_i;
  logic [num_x_lp-1:0] south_valid_i, south_ready_o, south_valid_o, south_ready_i;

  // all eight edge lanes, see exit_port for the lane order
  logic [7:0] edge_valid;
  logic [7:0] edge_rdy_out;
  logic [7:0] edge_rdy_in;
  pkt_u [7:0] edge_data;

  integer      seed = 63038;
  logic        bp_on;
  logic [31:0] bp_rnd;
  int          cycle_cnt;

  `include "tb_pod_model.svh"

  assign edge_valid   = {south_valid_o, north_valid_o, east_valid_o, west_valid_o};
  assign edge_rdy_out = {south_ready_o, north_ready_o, east_ready_o, west_ready_o};
  assign edge_rdy_in  = {south_ready_i, north_ready_i, east_ready_i, west_ready_i};
  assign edge_data    = {south_data_o, north_data_o, east_data_o, west_data_o};

  pod_array #(
    .num_pods_x_p(num_x_lp), .num_pods_y_p(num_y_lp), .reset_depth_p(reset_depth_lp)
  ) u_dut (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .tag_i(tag_i),
    .west_data_i(west_data_i), .west_valid_i(west_valid_i), .west_ready_o(west_ready_o),
    .west_data_o(west_data_o), .west_valid_o(west_valid_o), .west_ready_i(west_ready_i),
    .east_data_i(east_data_i), .east_valid_i(east_valid_i), .east_ready_o(east_ready_o),
    .east_data_o(east_data_o), .east_valid_o(east_valid_o), .east_ready_i(east_ready_i),
    .north_data_i(north_data_i), .north_valid_i(north_valid_i),
    .north_ready_o(north_ready_o), .north_data_o(north_data_o),
    .north_valid_o(north_valid_o), .north_ready_i(north_ready_i),
    .south_data_i(south_data_i), .south_valid_i(south_valid_i),
    .south_ready_o(south_ready_o), .south_data_o(south_data_o),
    .south_valid_o(south_valid_o), .south_ready_i(south_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "run aborted");
  endtask

  task automatic check_pkt(input string name, input pkt_u exp, input pkt_u got);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s expected %h actual %h",
                          $time, name, 32'(exp), 32'(got)));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s expected %b actual %b", $time, name, exp, got));
    end
  endtask

  function automatic string port_name(input int port, input string sig);
    string side;
    case (port / 2)
      0:       side = "west";
      1:       side = "east";
      2:       side = "north";
      default: side = "south";
    endcase
    return $sformatf("%s_%s[%0d]", side, sig, port % 2);
  endfunction

  // any edge lane of the pod opens with its router, pick one per pod
  function automatic logic pod_ready(input int pod);
    return (pod % 2 == 0) ? west_ready_o[pod / 2] : east_ready_o[pod / 2];
  endfunction

  task automatic match_arrival(input int port, input pkt_u got);
    int   hit;
    int   first;
    logic overtaken;
    hit       = -1;
    first     = -1;
    overtaken = 1'b0;
    for (int i = 0; i < exp_pkt_q.size(); i++) begin
      if (exp_port_q[i] == port) begin
        if (first < 0) begin
          first = i;
        end
        if ((hit < 0) && (got == exp_pkt_q[i])) begin
          hit = i;
        end
      end
    end
    if (first < 0) begin
      abort_run($sformatf("unexpected packet %h left the array on %s at %0t",
                          32'(got), port_name(port, "data_o"), $time));
    end else begin
      // without a match the oldest entry is compared and reported
      if (hit < 0) begin
        hit = first;
      end
      for (int j = 0; j < hit; j++) begin
        if ((exp_port_q[j] == port) && (exp_src_q[j] == exp_src_q[hit])) begin
          overtaken = 1'b1;
        end
      end
      if (overtaken) begin
        abort_run($sformatf("packet on %s overtook an earlier one from the same source at %0t",
                            port_name(port, "data_o"), $time));
      end else begin
        check_pkt(port_name(port, "data_o"), exp_pkt_q[hit], got);
        outstanding[exp_src_q[hit]]--;
        exp_pkt_q.delete(hit);
        exp_port_q.delete(hit);
        exp_src_q.delete(hit);
      end
    end
  endtask

  // frame is start bit, four index bits msb first, payload
  task automatic send_frame(input int pod, input logic hold);
    logic [5:0] bits;
    int         n;
    bits = {1'b1, 4'(pod), hold};
    for (int i = 5; i >= 0; i--) begin
      @(posedge clk_i);
      tag_i <= bits[i];
    end
    @(posedge clk_i);
    tag_i <= 1'b0;
    n = 1;
    @(negedge clk_i);
    while ((pod_ready(pod) != !hold) && (n < reset_depth_lp + 2)) begin
      @(negedge clk_i);
      n++;
    end
    check_flag($sformatf("ready of pod %0d", pod), !hold, pod_ready(pod));
  endtask

  task automatic send_pkt(input int side, input int lane, input pkt_u pkt);
    @(posedge clk_i);
    if (side == 0) begin
      west_data_i[lane]  <= pkt;
      west_valid_i[lane] <= 1'b1;
    end else begin
      north_data_i[lane]  <= pkt;
      north_valid_i[lane] <= 1'b1;
    end
    @(negedge clk_i);
    while (!((side == 0) ? west_ready_o[lane] : north_ready_o[lane])) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    if (side == 0) begin
      west_valid_i[lane] <= 1'b0;
    end else begin
      north_valid_i[lane] <= 1'b0;
    end
  endtask

  // one request in flight per source, the response is awaited before returning
  task automatic issue_req(input int side, input int lane, input int tx, input int ty,
                           input logic store, input int addr, input logic [15:0] data);
    pkt_u req;
    pkt_u rsp;
    int   src_x;
    int   src_y;
    int   pod;
    src_x = (side == 0) ? 0 : lane + 1;
    src_y = (side == 0) ? lane + 1 : 0;
    pod   = (ty - 1) * num_x_lp + (tx - 1);
    req            = '0;
    req.req.dest_x = cord_width'(tx);
    req.req.dest_y = cord_width'(ty);
    req.req.op     = store ? op_store : op_load;
    req.req.src_x  = cord_width'(src_x);
    req.req.src_y  = cord_width'(src_y);
    req.req.addr   = addr_width'(addr);
    req.req.data   = data;
    rsp            = '0;
    rsp.rsp.dest_x = cord_width'(src_x);
    rsp.rsp.dest_y = cord_width'(src_y);
    rsp.rsp.op     = store ? op_store_ack : op_load_data;
    // answering pod reports its own coordinates
    rsp.rsp.pad    = pad_width'({cord_width'(tx), cord_width'(ty)});
    rsp.rsp.data   = store ? data : model_mem[pod][addr];
    if (store) begin
      model_mem[pod][addr] = data;
    end
    expect_pkt(exit_port(tx, ty, src_x, src_y), side * 2 + lane, rsp);
    send_pkt(side, lane, req);
    while (outstanding[side * 2 + lane] != 0) begin
      @(posedge clk_i);
    end
  endtask

  // west and north streams own disjoint words so their order never matters
  task automatic mem_stream(input int side);
    logic [31:0] r;
    for (int k = 0; k < n_mem_lp; k++) begin
      r = $random(seed);
      issue_req(side, int'(r[2]), 1 + int'(r[0]), 1 + int'(r[1]), r[4],
                2 * side + int'(r[3]), r[31:16]);
    end
  endtask

  // back to back packets to edge coordinates
  task automatic pass_stream(input int side);
    logic [31:0] r;
    pkt_u        pkt;
    int          lane;
    int          dx;
    int          dy;
    for (int k = 0; k < n_pass_lp; k++) begin
      r    = $random(seed);
      pkt  = $random(seed);
      lane = int'(r[0]);
      dx   = 1 + int'(r[3]);
      dy   = int'(r[4:3]);
      // exit east, west, south or north
      case (r[2:1])
        2'd0:    dx = num_x_lp + 1;
        2'd1:    dx = 0;
        2'd2:    dy = num_y_lp + 1;
        default: dy = 0;
      endcase
      pkt.req.dest_x = cord_width'(dx);
      pkt.req.dest_y = cord_width'(dy);
      expect_pkt(exit_port((side == 0) ? 1 : lane + 1, (side == 0) ? lane + 1 : 1, dx, dy),
                 side * 2 + lane, pkt);
      send_pkt(side, lane, pkt);
    end
  endtask

  task automatic run_traffic();
    fork
      mem_stream(0);
      mem_stream(1);
    join
    fork
      pass_stream(0);
      pass_stream(1);
    join
    while (exp_pkt_q.size() != 0) begin
      @(posedge clk_i);
    end
  endtask

  // edge back-pressure, each lane ready three cycles in four
  always @(posedge clk_i) begin
    bp_rnd = $random(seed);
    if (bp_on) begin
      west_ready_i  <= bp_rnd[1:0] | bp_rnd[3:2];
      east_ready_i  <= bp_rnd[5:4] | bp_rnd[7:6];
      north_ready_i <= bp_rnd[9:8] | bp_rnd[11:10];
      south_ready_i <= bp_rnd[13:12] | bp_rnd[15:14];
    end else begin
      west_ready_i  <= '1;
      east_ready_i  <= '1;
      north_ready_i <= '1;
      south_ready_i <= '1;
    end
  end

  // edge handshakes are stable by the falling edge
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      for (int p = 0; p < 8; p++) begin
        if (edge_valid[p] && edge_rdy_in[p]) begin
          match_arrival(p, edge_data[p]);
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit_lp) begin
      abort_run($sformatf("timeout: the run did not finish within %0d cycles", cycle_limit_lp));
    end
  end

  initial begin
    logic [31:0] r;
    int          pod;
    cycle_cnt     = 0;
    bp_on         = 1'b0;
    rst_n_i       = 1'b0;
    tag_i         = 1'b0;
    west_data_i   = '0;
    east_data_i   = '0;
    north_data_i  = '0;
    south_data_i  = '0;
    west_valid_i  = '0;
    east_valid_i  = '0;
    north_valid_i = '0;
    south_valid_i = '0;
    west_ready_i  = '1;
    east_ready_i  = '1;
    north_ready_i = '1;
    south_ready_i = '1;
    init_model();
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    // pods stay in reset until a tag frame clears them
    repeat (12) begin
      @(negedge clk_i);
      for (int p = 0; p < 8; p++) begin
        check_flag(port_name(p, "ready_o"), 1'b0, edge_rdy_out[p]);
        check_flag(port_name(p, "valid_o"), 1'b0, edge_valid[p]);
      end
    end
    for (int p = 0; p < 4; p++) begin
      send_frame(p, 1'b0);
    end
    run_traffic();
    bp_on = 1'b1;
    run_traffic();
    r   = $random(seed);
    pod = int'(r[1:0]);
    send_frame(pod, 1'b1);
    send_frame(pod, 1'b0);
    clear_model_pod(pod);
    for (int p = 0; p < 4; p++) begin
      for (int a = 0; a < 4; a++) begin
        issue_req(0, 0, 1 + p % num_x_lp, 1 + p / num_x_lp, 1'b0, a, 16'h0000);
      end
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- compile.f
+incdir+.
mesh_pkg.sv
tag_client.sv
reset_delay.sv
pod_router.sv
pod_tile.sv
pod_array.sv
tb_pod_array.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --timing --timescale 1ns/10ps
TOP       = tb_pod_array
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
